// File: build.sh
#!/bin/sh
# builds the j1Soc testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module j1Soc_tb -f j1Soc.f -o simJ1Soc \
  && ./obj_dir/simJ1Soc > sim.log 2>&1 \
  || echo "SOME TESTS FAILED" >> sim.log
cat sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
exit 0

// File: hw/j1Alu.sv
`default_nettype none

module j1Alu (
  input  j1Pkg::aluOpT                  aluOp,
  input  j1Pkg::instrClassT             instrClass,
  input  logic [j1Pkg::dataWidth-1:0] instruction,
  input  logic [j1Pkg::dataWidth-1:0] top,
  input  logic [j1Pkg::dataWidth-1:0] second,
  input  logic [j1Pkg::dataWidth-1:0] returnTop,
  input  logic [j1Pkg::dataWidth-1:0] readData,
  input  logic [j1Pkg::dspWidth-1:0]  dataStackPointer,
  output logic [j1Pkg::dataWidth-1:0] newTop
);
  import j1Pkg::*;

  logic [dataWidth:0] minus;  // N - T with borrow in the top bit
  logic               signedLess;

  assign minus = {1'b1, ~top} + {1'b0, second} + 1'b1;

  // differing signs decide directly, otherwise the borrow does
  assign signedLess = (top[dataWidth-1] ^ second[dataWidth-1]) ? second[dataWidth-1] : minus[dataWidth];

  always_comb begin
    case (instrClass)
      classLiteral:  newTop = {1'b0, instruction[dataWidth-2:0]};
      classJump:     newTop = top;
      classCall:     newTop = top;
      classCondJump: newTop = second;  // drop the flag
      default: begin
        case (aluOp)
          opT:               newTop = top;
          opN:               newTop = second;
          opAdd:             newTop = top + second;
          opAnd:             newTop = top & second;
          opOr:              newTop = top | second;
          opXor:             newTop = top ^ second;
          opInvert:          newTop = ~top;
          opEqual:           newTop = {dataWidth{minus == '0}};
          opSignedLess:      newTop = {dataWidth{signedLess}};
          opShiftRightArith: newTop = {top[dataWidth-1], top[dataWidth-1:1]};
          opShiftLeft:       newTop = {top[dataWidth-2:0], 1'b0};
          opR:               newTop = returnTop;
          opSubtract:        newTop = minus[dataWidth-1:0];
          opReadData:        newTop = readData;
          opDepth:           newTop = dataWidth'(dataStackPointer);
          opUnsignedLess:    newTop = {dataWidth{minus[dataWidth]}};
          default:           newTop = top;
        endcase
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/j1Core.sv
`default_nettype none

module j1Core (
  input  logic                              clk,
  input  logic                              resetq,
  input  logic [j1Pkg::dataWidth-1:0]     instruction,
  input  logic [j1Pkg::dataWidth-1:0]     readData,
  output logic [j1Pkg::codeAddrWidth-1:0] codeAddr,
  output logic [j1Pkg::dataWidth-1:0]     memAddr,
  output logic [j1Pkg::dataWidth-1:0]     dout,
  output logic                              memWr,
  output logic                              ioWr,
  output logic                              ioRd
);
  import j1Pkg::*;

  instrClassT               instrClass;
  aluOpT                    aluOp;
  logic                     dataStackWrite;
  logic [1:0]               dataDelta;
  logic                     returnStackWrite;
  logic [1:0]               returnDelta;
  logic                     returnFromAlu;
  logic                     takeBranch;
  logic                     reboot;
  logic [codeAddrWidth-1:0] pc;
  logic [dspWidth-1:0]      dataStackPointer;
  logic [dataWidth-1:0]     top;
  logic [dataWidth-1:0]     second;
  logic [dataWidth-1:0]     returnTop;
  logic [dataWidth-1:0]     returnWriteData;
  logic [dataWidth-1:0]     newTop;

  assign memAddr = top;
  assign dout = second;

  j1Decode decode (
    .instruction(instruction),
    .reboot(reboot),
    .pcReturn(pc[codeAddrWidth-1]),
    .topNonZero(|top),
    .instrClass(instrClass),
    .aluOp(aluOp),
    .dataStackWrite(dataStackWrite),
    .dataDelta(dataDelta),
    .returnStackWrite(returnStackWrite),
    .returnDelta(returnDelta),
    .returnFromAlu(returnFromAlu),
    .memWr(memWr),
    .ioWr(ioWr),
    .ioRd(ioRd),
    .takeBranch(takeBranch)
  );

  j1Alu alu (
    .aluOp(aluOp),
    .instrClass(instrClass),
    .instruction(instruction),
    .top(top),
    .second(second),
    .returnTop(returnTop),
    .readData(readData),
    .dataStackPointer(dataStackPointer),
    .newTop(newTop)
  );

  j1Result result (
    .clk(clk),
    .resetq(resetq),
    .instruction(instruction),
    .instrClass(instrClass),
    .takeBranch(takeBranch),
    .returnFromAlu(returnFromAlu),
    .dataDelta(dataDelta),
    .newTop(newTop),
    .returnTop(returnTop),
    .pc(pc),
    .codeAddr(codeAddr),
    .top(top),
    .dataStackPointer(dataStackPointer),
    .reboot(reboot),
    .returnWriteData(returnWriteData)
  );

  j1Stack #(.depth(dataDepth)) dataStack (
    .clk(clk),
    .we(dataStackWrite),
    .delta(dataDelta),
    .wd(top),  // old T is pushed under the new one
    .rd(second)
  );

  j1Stack #(.depth(returnDepth)) returnStack (
    .clk(clk),
    .we(returnStackWrite),
    .delta(returnDelta),
    .wd(returnWriteData),
    .rd(returnTop)
  );

endmodule

`default_nettype wire

// File: hw/j1Decode.sv
`default_nettype none

module j1Decode (
  input  logic [j1Pkg::dataWidth-1:0] instruction,
  input  logic                          reboot,
  input  logic                          pcReturn,
  input  logic                          topNonZero,
  output j1Pkg::instrClassT             instrClass,
  output j1Pkg::aluOpT                  aluOp,
  output logic                          dataStackWrite,
  output logic [1:0]                    dataDelta,
  output logic                          returnStackWrite,
  output logic [1:0]                    returnDelta,
  output logic                          returnFromAlu,
  output logic                          memWr,
  output logic                          ioWr,
  output logic                          ioRd,
  output logic                          takeBranch
);
  import j1Pkg::*;

  funcFieldT func;
  logic      isAlu;

  assign func = funcFieldT'(instruction[6:4]);
  assign aluOp = aluOpT'(instruction[11:8]);

  always_comb begin
    if (pcReturn || instruction[15]) begin
      instrClass = classLiteral;  // return flag behaves as a literal
    end else begin
      case (instruction[14:13])
        2'b00:   instrClass = classJump;
        2'b01:   instrClass = classCondJump;
        2'b10:   instrClass = classCall;
        default: instrClass = classAlu;
      endcase
    end
  end

  assign isAlu = (instrClass == classAlu);

  always_comb begin
    dataStackWrite = 1'b0;
    dataDelta = 2'b00;
    returnStackWrite = 1'b0;
    returnDelta = 2'b00;
    case (instrClass)
      classLiteral: begin
        dataStackWrite = 1'b1;
        dataDelta = 2'b01;
        if (pcReturn) begin
          returnDelta = 2'b11;  // pop the return address
        end
      end
      classCondJump: dataDelta = 2'b11;  // flag is consumed
      classCall: begin
        returnStackWrite = 1'b1;
        returnDelta = 2'b01;
      end
      classAlu: begin
        dataStackWrite = (func == funcTToN);
        dataDelta = instruction[1:0];
        returnStackWrite = (func == funcTToR);
        returnDelta = instruction[3:2];
      end
      default: ;
    endcase
    // nothing moves while the core reboots
    if (reboot) begin
      dataStackWrite = 1'b0;
      dataDelta = 2'b00;
      returnStackWrite = 1'b0;
      returnDelta = 2'b00;
    end
  end

  assign returnFromAlu = !reboot && isAlu && instruction[7];
  assign memWr = !reboot && isAlu && (func == funcMemWrite);
  assign ioWr = !reboot && isAlu && (func == funcIoWrite);
  assign ioRd = !reboot && isAlu && (func == funcIoRead);

  assign takeBranch = !reboot && ((instrClass == classJump) || (instrClass == classCall) ||
                                  ((instrClass == classCondJump) && !topNonZero));

endmodule

`default_nettype wire

// File: hw/j1Memory.sv
`default_nettype none

module j1Memory (
  input  logic                                    clk,
  input  logic [j1Pkg::codeAddrWidth-1:0]       codeAddr,
  input  logic [j1Pkg::dataWidth-1:0]           memAddr,
  input  logic [j1Pkg::dataWidth-1:0]           dout,
  input  logic                                    memWr,
  input  logic                                    ioWr,
  input  logic                                    ioRd,
  input  logic                                    loadWe,
  input  logic [$clog2(j1Pkg::codeRamDepth)-1:0] loadAddr,
  input  logic [j1Pkg::dataWidth-1:0]           loadData,
  input  logic [j1Pkg::dataWidth-1:0]           ioDin,
  output logic [j1Pkg::dataWidth-1:0]           instruction,
  output logic [j1Pkg::dataWidth-1:0]           readData,
  output logic [j1Pkg::dataWidth-1:0]           ioAddr,
  output logic [j1Pkg::dataWidth-1:0]           ioDout,
  output logic                                    ioWrOut,
  output logic                                    ioRdOut
);
  import j1Pkg::*;

  localparam int codeIndexWidth = $clog2(codeRamDepth);
  localparam int dataIndexWidth = $clog2(dataRamDepth);

  logic [dataWidth-1:0] codeRam [codeRamDepth];
  logic [dataWidth-1:0] dataRam [dataRamDepth];
  logic                 inIo;

  assign inIo = (memAddr >= ioBase);

  always_ff @(posedge clk) begin
    if (loadWe) begin
      codeRam[loadAddr] <= loadData;
    end
    instruction <= codeRam[codeAddr[codeIndexWidth-1:0]];  // return flag bit ignored
  end

  always_ff @(posedge clk) begin
    if (memWr && !inIo) begin
      dataRam[memAddr[dataIndexWidth-1:0]] <= dout;
    end
  end

  assign readData = inIo ? ioDin : dataRam[memAddr[dataIndexWidth-1:0]];

  // outside port stays quiet below the window
  assign ioAddr = inIo ? memAddr : '0;
  assign ioDout = inIo ? dout : '0;
  assign ioWrOut = ioWr && inIo;
  assign ioRdOut = ioRd && inIo;

endmodule

`default_nettype wire

// File: hw/j1Pkg.sv
`default_nettype none

package j1Pkg;

  localparam int dataWidth = 16;
  localparam int codeAddrWidth = 13;  // top bit flags a return
  localparam int codeRamDepth = 4096;
  localparam int dataRamDepth = 256;
  localparam logic [dataWidth-1:0] ioBase = 16'h4000;  // start of io window

  localparam int dataDepth = 15;
  localparam int returnDepth = 17;
  localparam int dspWidth = $clog2(dataDepth + 1);

  typedef enum logic [2:0] {
    classLiteral,
    classJump,
    classCondJump,
    classCall,
    classAlu
  } instrClassT;

  typedef enum logic [3:0] {
    opT,
    opN,
    opAdd,
    opAnd,
    opOr,
    opXor,
    opInvert,
    opEqual,
    opSignedLess,
    opShiftRightArith,
    opShiftLeft,
    opR,
    opSubtract,
    opReadData,
    opDepth,
    opUnsignedLess
  } aluOpT;

  typedef enum logic [2:0] {
    funcNone     = 3'd0,
    funcTToN     = 3'd1,
    funcTToR     = 3'd2,
    funcMemWrite = 3'd3,
    funcIoWrite  = 3'd4,
    funcIoRead   = 3'd5
  } funcFieldT;

endpackage

`default_nettype wire

// File: hw/j1Result.sv
`default_nettype none

module j1Result (
  input  logic                              clk,
  input  logic                              resetq,
  input  logic [j1Pkg::dataWidth-1:0]     instruction,
  input  j1Pkg::instrClassT                 instrClass,
  input  logic                              takeBranch,
  input  logic                              returnFromAlu,
  input  logic [1:0]                        dataDelta,
  input  logic [j1Pkg::dataWidth-1:0]     newTop,
  input  logic [j1Pkg::dataWidth-1:0]     returnTop,
  output logic [j1Pkg::codeAddrWidth-1:0] pc,
  output logic [j1Pkg::codeAddrWidth-1:0] codeAddr,
  output logic [j1Pkg::dataWidth-1:0]     top,
  output logic [j1Pkg::dspWidth-1:0]      dataStackPointer,
  output logic                              reboot,
  output logic [j1Pkg::dataWidth-1:0]     returnWriteData
);
  import j1Pkg::*;

  logic [codeAddrWidth-1:0] pcPlusOne;
  logic [codeAddrWidth-1:0] pcNew;
  logic [dspWidth-1:0]      dspNew;
  logic [dataWidth-1:0]     topNew;

  assign pcPlusOne = pc + 1'b1;
  assign dspNew = dataStackPointer + {{(dspWidth - 2){dataDelta[1]}}, dataDelta};
  assign topNew = reboot ? top : newTop;  // hold T during reboot

  always_comb begin
    if (reboot) begin
      pcNew = '0;
    end else if (takeBranch) begin
      pcNew = instruction[codeAddrWidth-1:0];
    end else if (pc[codeAddrWidth-1] || returnFromAlu) begin
      pcNew = returnTop[codeAddrWidth:1];  // return address is stored shifted
    end else begin
      pcNew = pcPlusOne;
    end
  end

  assign codeAddr = pcNew;  // ram registers it into next instruction

  assign returnWriteData = (instrClass == classCall) ?
                           {{(dataWidth - codeAddrWidth - 1){1'b0}}, pcPlusOne, 1'b0} : top;

  always_ff @(posedge clk) begin
    if (!resetq) begin
      reboot <= 1'b1;
      pc <= '0;
      dataStackPointer <= '0;
      top <= '0;
    end else begin
      reboot <= 1'b0;
      pc <= pcNew;
      dataStackPointer <= dspNew;
      top <= topNew;
    end
  end

endmodule

`default_nettype wire

// File: hw/j1Soc.sv
`default_nettype none

module j1Soc (
  input  logic                                    clk,
  input  logic                                    resetq,
  input  logic                                    loadWe,
  input  logic [$clog2(j1Pkg::codeRamDepth)-1:0] loadAddr,
  input  logic [j1Pkg::dataWidth-1:0]           loadData,
  input  logic [j1Pkg::dataWidth-1:0]           ioDin,
  output logic [j1Pkg::dataWidth-1:0]           ioAddr,
  output logic [j1Pkg::dataWidth-1:0]           ioDout,
  output logic                                    ioWr,
  output logic                                    ioRd
);
  import j1Pkg::*;

  logic [codeAddrWidth-1:0] codeAddr;
  logic [dataWidth-1:0]     instruction;
  logic [dataWidth-1:0]     readData;
  logic [dataWidth-1:0]     memAddr;
  logic [dataWidth-1:0]     dout;
  logic                     memWr;
  logic                     coreIoWr;
  logic                     coreIoRd;

  j1Core core (
    .clk(clk),
    .resetq(resetq),
    .instruction(instruction),
    .readData(readData),
    .codeAddr(codeAddr),
    .memAddr(memAddr),
    .dout(dout),
    .memWr(memWr),
    .ioWr(coreIoWr),
    .ioRd(coreIoRd)
  );

  j1Memory memory (
    .clk(clk),
    .codeAddr(codeAddr),
    .memAddr(memAddr),
    .dout(dout),
    .memWr(memWr),
    .ioWr(coreIoWr),
    .ioRd(coreIoRd),
    .loadWe(loadWe),
    .loadAddr(loadAddr),
    .loadData(loadData),
    .ioDin(ioDin),
    .instruction(instruction),
    .readData(readData),
    .ioAddr(ioAddr),
    .ioDout(ioDout),
    .ioWrOut(ioWr),
    .ioRdOut(ioRd)
  );

endmodule

`default_nettype wire

// File: hw/j1Stack.sv
`default_nettype none

module j1Stack #(
  parameter int depth = 15
) (
  input  logic                          clk,
  input  logic                          we,
  input  logic [1:0]                    delta,
  input  logic [j1Pkg::dataWidth-1:0] wd,
  output logic [j1Pkg::dataWidth-1:0] rd
);
  import j1Pkg::*;

  localparam int ptrWidth = $clog2(depth);

  logic [dataWidth-1:0] store [depth];
  logic [ptrWidth-1:0] ptr = '0;  // entry holding the current top
  logic [ptrWidth-1:0] ptrNew;

  // pointer wraps around at depth, which need not be a power of two
  always_comb begin
    case (delta)
      2'b01:   ptrNew = (ptr == ptrWidth'(depth - 1)) ? '0 : ptr + 1'b1;
      2'b11:   ptrNew = (ptr == '0) ? ptrWidth'(depth - 1) : ptr - 1'b1;
      default: ptrNew = ptr;
    endcase
  end

  always_ff @(posedge clk) begin
    ptr <= ptrNew;
    if (we) begin
      store[ptrNew] <= wd;  // push lands at new top
    end
  end

  assign rd = store[ptr];  // word below T

endmodule

`default_nettype wire

// File: j1Soc.f
hw/j1Pkg.sv
hw/j1Stack.sv
hw/j1Decode.sv
hw/j1Alu.sv
hw/j1Result.sv
hw/j1Core.sv
hw/j1Memory.sv
hw/j1Soc.sv
tests/tbClock.sv
tests/j1Monitor.sv
tests/j1Soc_checker.sv
tests/j1Soc_tb.sv

// File: tests/j1Monitor.sv
`default_nettype none

module j1Monitor (
  input logic                          clk,
  input logic                          ioWr,
  input logic                          ioRd,
  input logic [j1Pkg::dataWidth-1:0] ioAddr,
  input logic [j1Pkg::dataWidth-1:0] ioDout
);
  import j1Pkg::*;

  string                testName;
  logic [dataWidth-1:0] expAddr [4];
  logic [dataWidth-1:0] expData [4];
  int                   expCount;
  int                   gotCount;
  int                   expReads;
  int                   gotReads;
  int                   mismatches;
  bit                   armed = 1'b0;
  bit                   testDone = 1'b0;
  int                   passCount = 0;
  int                   failCount = 0;
  int                   strayWrites = 0;
  int                   strayReads = 0;

  task automatic startTest(input string name, input int count, input int reads);
    testName = name;
    expCount = count;
    gotCount = 0;
    expReads = reads;
    gotReads = 0;
    mismatches = 0;
    testDone = 1'b0;
    armed = 1'b1;
  endtask

  task automatic setExpected(input int idx, input logic [15:0] addr, input logic [15:0] data);
    expAddr[idx] = addr;
    expData[idx] = data;
  endtask

  // sampled mid-cycle, where the combinational port is settled
  always @(negedge clk) begin
    if (ioRd) begin
      if (!armed) begin
        $display("an I/O read arrived while no test expected one (addr %h)", ioAddr);
        strayReads++;
      end else begin
        gotReads++;
      end
    end
    if (ioWr) begin
      if (!armed) begin
        $display("an I/O write arrived while no test expected one (addr %h)", ioAddr);
        strayWrites++;
      end else begin
        if (ioAddr !== expAddr[gotCount]) begin
          $display("CHECK FAILED %s write %0d ioAddr: got %h expected %h",
                   testName, gotCount, ioAddr, expAddr[gotCount]);
          mismatches++;
        end
        if (ioDout !== expData[gotCount]) begin
          $display("CHECK FAILED %s write %0d ioDout: got %h expected %h",
                   testName, gotCount, ioDout, expData[gotCount]);
          mismatches++;
        end
        gotCount++;
        if (gotCount == expCount) begin
          if (gotReads != expReads) begin
            $display("CHECK FAILED %s ioRd count: got %h expected %h",
                     testName, gotReads, expReads);
            mismatches++;
          end
          if (mismatches == 0) begin
            $display("pass  %s", testName);
            passCount++;
          end else begin
            $display("fail  %s (%0d mismatches)", testName, mismatches);
            failCount++;
          end
          armed = 1'b0;
          testDone = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/j1Soc_checker.sv
`default_nettype none

module j1Soc_checker (
  input logic                              clk,
  input logic                              resetq,
  input logic                              ioWr,
  input logic                              ioRd,
  input logic                              memWr,
  input logic [j1Pkg::codeAddrWidth-1:0] pc,
  input logic [j1Pkg::dataWidth-1:0]     top
);
  import j1Pkg::*;

  // strobes quiet one cycle into reset
  resetQuiet: assert property (@(posedge clk) !resetq |=> (!ioWr && !ioRd && !memWr))
    else $error("strobe active in the cycle after reset");

  resetState: assert property (@(posedge clk) !resetq |=> (pc == '0 && top == '0))
    else $error("pc or T not cleared by reset");

  ioExclusive: assert property (@(posedge clk) disable iff (!resetq) !(ioWr && ioRd))
    else $error("ioWr and ioRd high together");

endmodule

bind j1Core j1Soc_checker chk (
  .clk(clk),
  .resetq(resetq),
  .ioWr(ioWr),
  .ioRd(ioRd),
  .memWr(memWr),
  .pc(pc),
  .top(top)
);

`default_nettype wire

// File: tests/j1Soc_tb.sv
`default_nettype none

module j1Soc_tb;
  import j1Pkg::*;

  localparam int rowCount = 10;

  logic        clk;
  logic        resetq;
  logic        loadWe;
  logic [11:0] loadAddr;
  logic [15:0] loadData;
  logic [15:0] ioDin;
  logic [15:0] ioAddr;
  logic [15:0] ioDout;
  logic        ioWr;
  logic        ioRd;

  string       rowName [rowCount];
  logic [15:0] rowCode [rowCount][16];
  int          rowLen [rowCount];
  logic [15:0] rowIoDin [rowCount];
  logic [15:0] rowExpAddr [rowCount][4];
  logic [15:0] rowExpData [rowCount][4];
  int          rowExpCount [rowCount];
  int          rowExpReads [rowCount];
  logic [31:0] rngState = 32'd58;

  tbClock clkGen (.clk(clk));

  j1Soc uut (
    .clk(clk),
    .resetq(resetq),
    .loadWe(loadWe),
    .loadAddr(loadAddr),
    .loadData(loadData),
    .ioDin(ioDin),
    .ioAddr(ioAddr),
    .ioDout(ioDout),
    .ioWr(ioWr),
    .ioRd(ioRd)
  );

  j1Monitor mon (.clk(clk), .ioWr(ioWr), .ioRd(ioRd), .ioAddr(ioAddr), .ioDout(ioDout));

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] v;
    v = x ^ (x << 13);
    v = v ^ (v >> 17);
    return v ^ (v << 5);
  endfunction

  function automatic logic [15:0] nextOperand();
    rngState = xorshift(rngState);
    return {1'b0, rngState[14:0]};  // literals carry 15 bits
  endfunction

  function automatic logic [15:0] lit(input logic [15:0] v);
    return {1'b1, v[14:0]};
  endfunction

  function automatic logic [15:0] jumpTo(input int a);
    return {3'b000, 13'(a)};
  endfunction

  function automatic logic [15:0] condJumpTo(input int a);
    return {3'b001, 13'(a)};
  endfunction

  function automatic logic [15:0] callTo(input int a);
    return {3'b010, 13'(a)};
  endfunction

  function automatic logic [15:0] aluWord(input aluOpT op, input logic ret, input funcFieldT f,
                                          input logic [1:0] rDelta, input logic [1:0] dDelta);
    return {3'b011, 1'b0, 4'(op), ret, 3'(f), rDelta, dDelta};
  endfunction

  // reference model of the ALU field, T on top and N below
  function automatic logic [15:0] aluModel(input aluOpT op, input logic [15:0] t,
                                           input logic [15:0] n, input logic [15:0] r,
                                           input int depthNow);
    case (op)
      opT:               return t;
      opN:               return n;
      opAdd:             return n + t;
      opAnd:             return n & t;
      opOr:              return n | t;
      opXor:             return n ^ t;
      opInvert:          return ~t;
      opEqual:           return (n == t) ? 16'hffff : 16'h0000;
      opSignedLess:      return ($signed(n) < $signed(t)) ? 16'hffff : 16'h0000;
      opShiftRightArith: return 16'($signed(t) >>> 1);
      opShiftLeft:       return t << 1;
      opR:               return r;
      opSubtract:        return n - t;
      opDepth:           return 16'(depthNow);
      opUnsignedLess:    return (n < t) ? 16'hffff : 16'h0000;
      default:           return 16'hxxxx;
    endcase
  endfunction

  task automatic addWord(input int row, input logic [15:0] w);
    rowCode[row][rowLen[row]] = w;
    rowLen[row]++;
  endtask

  task automatic addExpect(input int row, input logic [15:0] a, input logic [15:0] d);
    rowExpAddr[row][rowExpCount[row]] = a;
    rowExpData[row][rowExpCount[row]] = d;
    rowExpCount[row]++;
  endtask

  task automatic ioWriteSeq(input int row, input logic [15:0] addr);
    addWord(row, lit(addr));
    addWord(row, aluWord(opN, 1'b0, funcIoWrite, 2'b00, 2'b11));
  endtask

  // three ops on operands b over n, each result written then dropped
  task automatic addAluRow(input int row, input string name, input aluOpT op0,
                           input aluOpT op1, input aluOpT op2, input bit useR);
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] n;
    aluOpT       ops [3];
    a = nextOperand();
    b = nextOperand();
    n = useR ? a : ~a;  // inverted a gives a negative N
    ops[0] = op0;
    ops[1] = op1;
    ops[2] = op2;
    rowName[row] = name;
    addWord(row, lit(a));
    if (!useR) addWord(row, aluWord(opInvert, 1'b0, funcNone, 2'b00, 2'b00));
    addWord(row, lit(b));
    if (useR) addWord(row, aluWord(opT, 1'b0, funcTToR, 2'b01, 2'b00));
    for (int k = 0; k < 3; k++) begin
      addWord(row, aluWord(ops[k], 1'b0, funcTToN, 2'b00, 2'b01));
      ioWriteSeq(row, 16'h4000 + 16'(k));
      addWord(row, aluWord(opN, 1'b0, funcNone, 2'b00, 2'b11));
      addExpect(row, 16'h4000 + 16'(k), aluModel(ops[k], b, n, b, 2));
    end
    addWord(row, jumpTo(rowLen[row]));
  endtask

  task automatic buildTable();
    logic [15:0] v;
    for (int r = 0; r < rowCount; r++) begin
      rowLen[r] = 0;
      rowExpCount[r] = 0;
      rowExpReads[r] = 0;
      rowIoDin[r] = nextOperand();
    end
    rowName[0] = "literal and io write";
    addWord(0, lit(16'h1234));
    ioWriteSeq(0, 16'h4000);
    addWord(0, lit(16'hffff));  // bit 15 is the class bit
    ioWriteSeq(0, 16'h4002);
    addWord(0, jumpTo(rowLen[0]));
    addExpect(0, 16'h4000, 16'h1234);
    addExpect(0, 16'h4002, 16'h7fff);
    addAluRow(1, "alu T N add", opT, opN, opAdd, 1'b0);
    addAluRow(2, "alu and or xor", opAnd, opOr, opXor, 1'b0);
    addAluRow(3, "alu invert equal signedLess", opInvert, opEqual, opSignedLess, 1'b0);
    addAluRow(4, "alu shifts subtract", opShiftRightArith, opShiftLeft, opSubtract, 1'b0);
    addAluRow(5, "alu R depth unsignedLess", opR, opDepth, opUnsignedLess, 1'b1);
    rowName[6] = "conditional jump";
    rowCode[6] = '{lit(0), condJumpTo(4), lit(16'h0bad), jumpTo(5), lit(16'h0011), lit(16'h4000),
                   aluWord(opN, 1'b0, funcIoWrite, 2'b00, 2'b11),
                   aluWord(opN, 1'b0, funcNone, 2'b00, 2'b11), lit(1), condJumpTo(12),
                   lit(16'h0022), jumpTo(13), lit(16'h0bad), lit(16'h4001),
                   aluWord(opN, 1'b0, funcIoWrite, 2'b00, 2'b11), jumpTo(15)};
    rowLen[6] = 16;
    addExpect(6, 16'h4000, 16'h0011);
    addExpect(6, 16'h4001, 16'h0022);
    rowName[7] = "call and return";
    addWord(7, lit(16'h000a));
    ioWriteSeq(7, 16'h4000);
    addWord(7, callTo(8));
    addWord(7, lit(16'h000c));
    ioWriteSeq(7, 16'h4000);
    addWord(7, jumpTo(7));
    addWord(7, lit(16'h000b));  // subroutine at 8
    ioWriteSeq(7, 16'h4000);
    addWord(7, aluWord(opT, 1'b1, funcNone, 2'b11, 2'b00));
    addExpect(7, 16'h4000, 16'h000a);
    addExpect(7, 16'h4000, 16'h000b);
    addExpect(7, 16'h4000, 16'h000c);
    rowName[8] = "data ram and io read";
    v = nextOperand();
    addWord(8, lit(v));
    addWord(8, lit(16'h0020));
    addWord(8, aluWord(opN, 1'b0, funcMemWrite, 2'b00, 2'b11));
    addWord(8, lit(16'h0020));
    addWord(8, aluWord(opReadData, 1'b0, funcNone, 2'b00, 2'b00));
    addWord(8, lit(1));
    addWord(8, aluWord(opAdd, 1'b0, funcNone, 2'b00, 2'b11));
    ioWriteSeq(8, 16'h4000);
    addWord(8, lit(16'h4000));
    addWord(8, aluWord(opReadData, 1'b0, funcIoRead, 2'b00, 2'b00));
    ioWriteSeq(8, 16'h4001);
    addWord(8, jumpTo(rowLen[8]));
    addExpect(8, 16'h4000, v + 16'd1);
    addExpect(8, 16'h4001, rowIoDin[8]);
    rowExpReads[8] = 1;
    rowName[9] = "stack depth";
    for (int i = 0; i < 5; i++) addWord(9, lit(nextOperand()));
    addWord(9, aluWord(opDepth, 1'b0, funcTToN, 2'b00, 2'b01));
    ioWriteSeq(9, 16'h4000);
    addWord(9, aluWord(opDepth, 1'b0, funcTToN, 2'b00, 2'b01));  // one more item now
    ioWriteSeq(9, 16'h4001);
    addWord(9, jumpTo(rowLen[9]));
    addExpect(9, 16'h4000, 16'd5);
    addExpect(9, 16'h4001, 16'd6);
  endtask

  initial begin
    #(rowCount * 200);
    $display("timeout: the test programs did not finish in time");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    resetq = 1'b0;
    loadWe = 1'b0;
    loadAddr = '0;
    loadData = '0;
    ioDin = '0;
    buildTable();
    @(posedge clk);
    #1;
    for (int r = 0; r < rowCount; r++) begin
      mon.startTest(rowName[r], rowExpCount[r], rowExpReads[r]);
      for (int i = 0; i < rowExpCount[r]; i++) begin
        mon.setExpected(i, rowExpAddr[r][i], rowExpData[r][i]);
      end
      resetq = 1'b0;
      ioDin = rowIoDin[r];
      for (int w = 0; w < rowLen[r]; w++) begin
        loadWe = 1'b1;
        loadAddr = 12'(w);
        loadData = rowCode[r][w];
        @(posedge clk);
        #1;
      end
      loadWe = 1'b0;
      repeat (3) begin
        @(posedge clk);
        #1;
      end
      resetq = 1'b1;
      wait (mon.testDone);
      @(posedge clk);
      #1;
    end
    $display("tests: %0d passed, %0d failed, %0d stray writes, %0d stray reads",
             mon.passCount, mon.failCount, mon.strayWrites, mon.strayReads);
    if (mon.failCount == 0 && mon.strayWrites == 0 && mon.strayReads == 0 &&
        mon.passCount == rowCount) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/tbClock.sv
`default_nettype none

module tbClock (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;  // period 4

endmodule

`default_nettype wire
